//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_bridge_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- logic/bridge_pkg.sv
package bridge_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] strb_t;
  typedef logic [3:0] axi_id_t;
  typedef logic [7:0] axi_len_t;
  typedef logic [1:0] beat_cnt_t;  // Beat index inside a line

  // Refill size, same encoding as the caches put on rd_type
  typedef enum logic [2:0] {
    REQ_WORD = 3'b010,
    REQ_LINE = 3'b100
  } req_type_e;

  localparam axi_id_t ID_INST = 4'd0;
  localparam axi_id_t ID_DATA = 4'd1;

  localparam int LINE_BEATS = 4;
  localparam axi_len_t LEN_LINE = axi_len_t'(LINE_BEATS - 1);
  localparam axi_len_t LEN_WORD = 8'd0;

  localparam logic [2:0] AXI_SIZE_WORD = 3'b010;  // 4 bytes per beat
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  // One pending AR transfer
  typedef struct packed {
    axi_id_t  id;
    addr_t    addr;
    axi_len_t len;
  } rd_req_t;

  typedef enum logic [1:0] {
    W_IDLE,
    W_SEND,
    W_WAIT_B
  } write_state_e;

endpackage

//--- logic/mem_bridge_top.sv
`timescale 1ns/1ps

module mem_bridge_top (
  input  logic                  aclk,
  input  logic                  reset,

  input  logic                  inst_rd_req,
  input  bridge_pkg::req_type_e inst_rd_type,
  input  bridge_pkg::addr_t     inst_rd_addr,
  output logic                  inst_rd_rdy,
  output logic                  inst_ret_valid,
  output logic                  inst_ret_last,
  output bridge_pkg::word_t     inst_ret_data,

  input  logic                  data_rd_req,
  input  bridge_pkg::req_type_e data_rd_type,
  input  bridge_pkg::addr_t     data_rd_addr,
  output logic                  data_rd_rdy,
  output logic                  data_ret_valid,
  output logic                  data_ret_last,
  output bridge_pkg::word_t     data_ret_data,

  input  logic                  data_wr_req,
  input  bridge_pkg::addr_t     data_wr_addr,
  input  bridge_pkg::strb_t     data_wr_wstrb,
  input  bridge_pkg::word_t     data_wr_data,
  output logic                  data_wr_rdy,

  output bridge_pkg::axi_id_t   arid,
  output bridge_pkg::addr_t     araddr,
  output bridge_pkg::axi_len_t  arlen,
  output logic [2:0]            arsize,
  output logic [1:0]            arburst,
  output logic                  arvalid,
  input  logic                  arready,

  input  bridge_pkg::axi_id_t   rid,
  input  bridge_pkg::word_t     rdata,
  input  logic                  rlast,
  input  logic                  rvalid,
  output logic                  rready,

  output bridge_pkg::axi_id_t   awid,
  output bridge_pkg::addr_t     awaddr,
  output bridge_pkg::axi_len_t  awlen,
  output logic [2:0]            awsize,
  output logic [1:0]            awburst,
  output logic                  awvalid,
  input  logic                  awready,

  output bridge_pkg::word_t     wdata,
  output bridge_pkg::strb_t     wstrb,
  output logic                  wlast,
  output logic                  wvalid,
  input  logic                  wready,

  input  logic                  bvalid,
  output logic                  bready
);

  logic                inst_busy;
  logic                data_busy;
  logic                write_busy;
  logic                issue_valid;
  bridge_pkg::axi_id_t issue_id;
  bridge_pkg::rd_req_t ar_slot;

  assign arid    = ar_slot.id;
  assign araddr  = ar_slot.addr;
  assign arlen   = ar_slot.len;
  assign arsize  = bridge_pkg::AXI_SIZE_WORD;
  assign arburst = bridge_pkg::AXI_BURST_INCR;

  assign awlen   = bridge_pkg::LEN_WORD;  // Stores are one beat
  assign awsize  = bridge_pkg::AXI_SIZE_WORD;
  assign awburst = bridge_pkg::AXI_BURST_INCR;

  read_request_arbiter read_request_arbiter_0 (
    .aclk        (aclk),
    .reset       (reset),
    .inst_rd_req (inst_rd_req),
    .inst_rd_type(inst_rd_type),
    .inst_rd_addr(inst_rd_addr),
    .data_rd_req (data_rd_req),
    .data_rd_type(data_rd_type),
    .data_rd_addr(data_rd_addr),
    .inst_busy   (inst_busy),
    .data_busy   (data_busy),
    .write_busy  (write_busy),
    .arready     (arready),
    .inst_rd_rdy (inst_rd_rdy),
    .data_rd_rdy (data_rd_rdy),
    .issue_valid (issue_valid),
    .issue_id    (issue_id),
    .ar          (ar_slot),
    .arvalid     (arvalid)
  );

  read_return_router read_return_router_0 (
    .aclk          (aclk),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_id      (issue_id),
    .rid           (rid),
    .rdata         (rdata),
    .rlast         (rlast),
    .rvalid        (rvalid),
    .rready        (rready),
    .inst_busy     (inst_busy),
    .data_busy     (data_busy),
    .inst_ret_valid(inst_ret_valid),
    .inst_ret_last (inst_ret_last),
    .inst_ret_data (inst_ret_data),
    .data_ret_valid(data_ret_valid),
    .data_ret_last (data_ret_last),
    .data_ret_data (data_ret_data)
  );

  write_issue_engine write_issue_engine_0 (
    .aclk      (aclk),
    .reset     (reset),
    .wr_req    (data_wr_req),
    .wr_addr   (data_wr_addr),
    .wr_wstrb  (data_wr_wstrb),
    .wr_data   (data_wr_data),
    .awready   (awready),
    .wready    (wready),
    .bvalid    (bvalid),
    .wr_rdy    (data_wr_rdy),
    .write_busy(write_busy),
    .awid      (awid),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wlast     (wlast),
    .wvalid    (wvalid),
    .bready    (bready)
  );

endmodule

//--- logic/read_request_arbiter.sv
`timescale 1ns/1ps

module read_request_arbiter (
  input  logic                  aclk,
  input  logic                  reset,
  input  logic                  inst_rd_req,
  input  bridge_pkg::req_type_e inst_rd_type,
  input  bridge_pkg::addr_t     inst_rd_addr,
  input  logic                  data_rd_req,
  input  bridge_pkg::req_type_e data_rd_type,
  input  bridge_pkg::addr_t     data_rd_addr,
  input  logic                  inst_busy,
  input  logic                  data_busy,
  input  logic                  write_busy,
  input  logic                  arready,
  output logic                  inst_rd_rdy,
  output logic                  data_rd_rdy,
  output logic                  issue_valid,
  output bridge_pkg::axi_id_t   issue_id,
  output bridge_pkg::rd_req_t   ar,
  output logic                  arvalid
);

  logic slot_full;
  logic inst_take;
  logic data_take;
  bridge_pkg::rd_req_t next_req;

  // Burst shape and aligned start address for one refill
  function automatic bridge_pkg::rd_req_t build_req(bridge_pkg::axi_id_t id,
                                                    bridge_pkg::req_type_e kind,
                                                    bridge_pkg::addr_t addr);
    bridge_pkg::rd_req_t req;
    req.id = id;
    if (kind == bridge_pkg::REQ_LINE) begin
      req.addr = {addr[31:4], 4'b0000};  // 16-byte line
      req.len  = bridge_pkg::LEN_LINE;
    end else begin
      req.addr = {addr[31:2], 2'b00};
      req.len  = bridge_pkg::LEN_WORD;
    end
    return req;
  endfunction

  // Data reads go first but wait behind an open store
  assign data_rd_rdy = !slot_full && !data_busy && !write_busy;
  assign inst_rd_rdy = !slot_full && !inst_busy && !data_rd_req;

  assign data_take = data_rd_req && data_rd_rdy;
  assign inst_take = inst_rd_req && inst_rd_rdy;

  assign issue_valid = data_take || inst_take;
  assign issue_id    = data_take ? bridge_pkg::ID_DATA : bridge_pkg::ID_INST;

  assign next_req = data_take ? build_req(issue_id, data_rd_type, data_rd_addr)
                              : build_req(issue_id, inst_rd_type, inst_rd_addr);

  always_ff @(posedge aclk) begin
    if (reset) begin
      slot_full <= 1'b0;
    end else if (issue_valid) begin
      slot_full <= 1'b1;
    end else if (arvalid && arready) begin
      slot_full <= 1'b0;  // AR taken, slot reopens next cycle
    end
  end

  always_ff @(posedge aclk) begin
    if (issue_valid) begin
      ar <= next_req;
    end
  end

  assign arvalid = slot_full;

endmodule

//--- logic/read_return_router.sv
`timescale 1ns/1ps

module read_return_router (
  input  logic                aclk,
  input  logic                reset,
  input  logic                issue_valid,
  input  bridge_pkg::axi_id_t issue_id,
  input  bridge_pkg::axi_id_t rid,
  input  bridge_pkg::word_t   rdata,
  input  logic                rlast,
  input  logic                rvalid,
  output logic                rready,
  output logic                inst_busy,
  output logic                data_busy,
  output logic                inst_ret_valid,
  output logic                inst_ret_last,
  output bridge_pkg::word_t   inst_ret_data,
  output logic                data_ret_valid,
  output logic                data_ret_last,
  output bridge_pkg::word_t   data_ret_data
);

  logic beat;
  logic inst_hit;
  logic data_hit;
  bridge_pkg::beat_cnt_t inst_beat;
  bridge_pkg::beat_cnt_t data_beat;

  assign beat     = rvalid && rready;
  assign inst_hit = beat && (rid == bridge_pkg::ID_INST);
  assign data_hit = beat && (rid == bridge_pkg::ID_DATA);

  // Outstanding flags and beat counters, one set per id
  always_ff @(posedge aclk) begin
    if (reset) begin
      rready    <= 1'b0;
      inst_busy <= 1'b0;
      data_busy <= 1'b0;
      inst_beat <= '0;
      data_beat <= '0;
    end else begin
      rready <= 1'b1;  // Always sink R after reset
      if (issue_valid && issue_id == bridge_pkg::ID_INST) begin
        inst_busy <= 1'b1;
      end else if (inst_hit && rlast) begin
        inst_busy <= 1'b0;
      end
      if (issue_valid && issue_id == bridge_pkg::ID_DATA) begin
        data_busy <= 1'b1;
      end else if (data_hit && rlast) begin
        data_busy <= 1'b0;
      end
      if (inst_hit) begin
        inst_beat <= rlast ? '0 : inst_beat + 1'b1;
      end
      if (data_hit) begin
        data_beat <= rlast ? '0 : data_beat + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      inst_ret_valid <= 1'b0;
      inst_ret_last  <= 1'b0;
      data_ret_valid <= 1'b0;
      data_ret_last  <= 1'b0;
    end else begin
      inst_ret_valid <= inst_hit;
      inst_ret_last  <= inst_hit && rlast;
      data_ret_valid <= data_hit;
      data_ret_last  <= data_hit && rlast;
    end
  end

  always_ff @(posedge aclk) begin
    if (inst_hit) begin
      inst_ret_data <= rdata;
    end
    if (data_hit) begin
      data_ret_data <= rdata;
    end
  end

endmodule

//--- logic/write_issue_engine.sv
`timescale 1ns/1ps

module write_issue_engine (
  input  logic                aclk,
  input  logic                reset,
  input  logic                wr_req,
  input  bridge_pkg::addr_t   wr_addr,
  input  bridge_pkg::strb_t   wr_wstrb,
  input  bridge_pkg::word_t   wr_data,
  input  logic                awready,
  input  logic                wready,
  input  logic                bvalid,
  output logic                wr_rdy,
  output logic                write_busy,
  output bridge_pkg::axi_id_t awid,
  output bridge_pkg::addr_t   awaddr,
  output logic                awvalid,
  output bridge_pkg::word_t   wdata,
  output bridge_pkg::strb_t   wstrb,
  output logic                wlast,
  output logic                wvalid,
  output logic                bready
);

  bridge_pkg::write_state_e state_q;
  bridge_pkg::write_state_e state_d;
  logic aw_done;
  logic w_done;
  logic aw_fire;
  logic w_fire;
  logic b_fire;

  assign wr_rdy     = (state_q == bridge_pkg::W_IDLE);
  assign write_busy = (state_q != bridge_pkg::W_IDLE);

  // AW and W run independently once the store is latched
  assign awvalid = (state_q == bridge_pkg::W_SEND) && !aw_done;
  assign wvalid  = (state_q == bridge_pkg::W_SEND) && !w_done;
  assign bready  = (state_q == bridge_pkg::W_WAIT_B);

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;
  assign b_fire  = bvalid && bready;

  assign awid  = bridge_pkg::ID_DATA;
  assign wlast = 1'b1;  // Single beat

  always_comb begin
    state_d = state_q;
    case (state_q)
      bridge_pkg::W_IDLE: begin
        if (wr_req) state_d = bridge_pkg::W_SEND;
      end
      bridge_pkg::W_SEND: begin
        if ((aw_done || aw_fire) && (w_done || w_fire)) state_d = bridge_pkg::W_WAIT_B;
      end
      bridge_pkg::W_WAIT_B: begin
        if (b_fire) state_d = bridge_pkg::W_IDLE;
      end
      default: state_d = bridge_pkg::W_IDLE;
    endcase
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      state_q <= bridge_pkg::W_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge aclk) begin
    if (reset || state_q == bridge_pkg::W_IDLE) begin
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else begin
      if (aw_fire) aw_done <= 1'b1;
      if (w_fire) w_done <= 1'b1;
    end
  end

  // Store payload, captured on acceptance
  always_ff @(posedge aclk) begin
    if (wr_req && wr_rdy) begin
      awaddr <= {wr_addr[31:2], 2'b00};
      wdata  <= wr_data;
      wstrb  <= wr_wstrb;
    end
  end

endmodule

//--- src.f
logic/bridge_pkg.sv
logic/read_request_arbiter.sv
logic/read_return_router.sv
logic/write_issue_engine.sv
logic/mem_bridge_top.sv
tests/bridge_checker.sv
tests/bridge_sva.sv
tests/mem_bridge_tb.sv

//--- tests/bridge_checker.sv
`timescale 1ns/1ps

module bridge_checker (
  input  logic                  aclk,
  input  logic                  reset,
  input  logic                  inst_rd_req,
  input  bridge_pkg::req_type_e inst_rd_type,
  input  bridge_pkg::addr_t     inst_rd_addr,
  input  logic                  inst_rd_rdy,
  input  logic                  inst_ret_valid,
  input  logic                  inst_ret_last,
  input  bridge_pkg::word_t     inst_ret_data,
  input  logic                  data_rd_req,
  input  bridge_pkg::req_type_e data_rd_type,
  input  bridge_pkg::addr_t     data_rd_addr,
  input  logic                  data_rd_rdy,
  input  logic                  data_ret_valid,
  input  logic                  data_ret_last,
  input  bridge_pkg::word_t     data_ret_data,
  input  logic                  data_wr_req,
  input  bridge_pkg::addr_t     data_wr_addr,
  input  bridge_pkg::strb_t     data_wr_wstrb,
  input  bridge_pkg::word_t     data_wr_data,
  input  logic                  data_wr_rdy,
  input  bridge_pkg::axi_id_t   arid,
  input  bridge_pkg::addr_t     araddr,
  input  bridge_pkg::axi_len_t  arlen,
  input  logic [2:0]            arsize,
  input  logic [1:0]            arburst,
  input  logic                  arvalid,
  input  logic                  arready,
  input  logic                  rready,
  input  bridge_pkg::axi_id_t   awid,
  input  bridge_pkg::axi_len_t  awlen,
  input  logic [2:0]            awsize,
  input  logic [1:0]            awburst,
  input  logic                  awvalid,
  input  logic                  awready,
  input  logic                  wlast,
  input  logic                  wvalid,
  input  logic                  wready,
  input  logic                  bvalid,
  input  logic                  bready,
  input  logic [95:0]           inst_name,
  input  logic [95:0]           data_name,
  input  logic [95:0]           wr_name,
  output int                    mismatches,
  output int                    faults
);

  bridge_pkg::word_t mirror [256];
  bridge_pkg::word_t inst_exp[$];
  bridge_pkg::word_t data_exp[$];
  bridge_pkg::word_t exp_word;
  bridge_pkg::addr_t exp_addr [2];
  bridge_pkg::axi_len_t exp_len [2];
  logic [95:0] tag [2];
  logic [95:0] wr_tag;
  logic [7:0] base;
  logic reset_q;
  logic write_open;

  // Same pattern as the memory model, built from the full word index
  function automatic bridge_pkg::word_t preload(logic [7:0] i);
    return {~i, i, i ^ 8'h5a, i + 8'hc3};
  endfunction

  initial begin
    mismatches = 0;
    faults = 0;
    for (int i = 0; i < 256; i++) mirror[i] = preload(i[7:0]);
  end

  always @(posedge aclk) begin
    reset_q <= reset;
    if (reset) begin
      write_open <= 1'b0;
    end else begin
      if (reset_q && (arvalid || awvalid || wvalid || bready || rready || inst_ret_valid
                      || data_ret_valid || !inst_rd_rdy || !data_rd_rdy || !data_wr_rdy)) begin
        $display("Control outputs are not idle in the first cycle after reset");
        faults++;
      end
      // Data port has priority when both ask in the same cycle
      if (inst_rd_req && inst_rd_rdy && data_rd_req) begin
        $display("Instruction read accepted while a data read was waiting");
        faults++;
      end
      if (inst_rd_req && inst_rd_rdy) begin
        base = (inst_rd_type == bridge_pkg::REQ_LINE) ? {inst_rd_addr[9:4], 2'b00}
                                                       : inst_rd_addr[9:2];
        exp_addr[0] = (inst_rd_type == bridge_pkg::REQ_LINE) ? {inst_rd_addr[31:4], 4'h0}
                                                              : {inst_rd_addr[31:2], 2'b00};
        exp_len[0] = (inst_rd_type == bridge_pkg::REQ_LINE) ? 8'd3 : 8'd0;
        tag[0] = inst_name;
        for (int k = 0; k <= int'(exp_len[0]); k++) inst_exp.push_back(mirror[base + k]);
      end
      if (data_rd_req && data_rd_rdy) begin
        base = (data_rd_type == bridge_pkg::REQ_LINE) ? {data_rd_addr[9:4], 2'b00}
                                                       : data_rd_addr[9:2];
        exp_addr[1] = (data_rd_type == bridge_pkg::REQ_LINE) ? {data_rd_addr[31:4], 4'h0}
                                                              : {data_rd_addr[31:2], 2'b00};
        exp_len[1] = (data_rd_type == bridge_pkg::REQ_LINE) ? 8'd3 : 8'd0;
        tag[1] = data_name;
        for (int k = 0; k <= int'(exp_len[1]); k++) data_exp.push_back(mirror[base + k]);
      end
      if (data_wr_req && data_wr_rdy) begin
        write_open <= 1'b1;
        wr_tag = wr_name;
        for (int b = 0; b < 4; b++)
          if (data_wr_wstrb[b]) mirror[data_wr_addr[9:2]][8*b +: 8] = data_wr_data[8*b +: 8];
      end
      if (bvalid && bready) write_open <= 1'b0;
      // A data read must not reach the bus ahead of an open store
      if (arvalid && arid == bridge_pkg::ID_DATA && write_open) begin
        $display("Data read address issued before the write response");
        faults++;
      end
      if (arvalid && arready) begin
        if (arid > 1) begin
          $display("Read address carries an unknown id %0d", arid);
          faults++;
        end else begin
          if (araddr !== exp_addr[arid[0]]) begin
            $display("Mismatch %0s araddr: expected %h, actual %h", tag[arid[0]],
                     exp_addr[arid[0]], araddr);
            mismatches++;
          end
          if (arlen !== exp_len[arid[0]]) begin
            $display("Mismatch %0s arlen: expected %0d, actual %0d", tag[arid[0]],
                     exp_len[arid[0]], arlen);
            mismatches++;
          end
          // 4-byte beats, incrementing burst
          if ({arsize, arburst} !== {3'b010, 2'b01}) begin
            $display("Mismatch %0s arsize/arburst: expected 2/1, actual %0d/%0d",
                     tag[arid[0]], arsize, arburst);
            mismatches++;
          end
        end
      end
      if (awvalid && awready) begin
        if (awid !== bridge_pkg::ID_DATA) begin
          $display("Mismatch %0s awid: expected %0d, actual %0d", wr_tag,
                   bridge_pkg::ID_DATA, awid);
          mismatches++;
        end
        if ({awlen, awsize, awburst} !== {8'd0, 3'b010, 2'b01}) begin
          $display("Mismatch %0s awlen/awsize/awburst: expected 0/2/1, actual %0d/%0d/%0d",
                   wr_tag, awlen, awsize, awburst);
          mismatches++;
        end
      end
      if (wvalid && wready && wlast !== 1'b1) begin
        $display("Mismatch %0s wlast: expected 1, actual %b", wr_tag, wlast);
        mismatches++;
      end
      if (inst_ret_valid) begin
        if (inst_exp.size() == 0) begin
          $display("Instruction port returned a beat that was never requested");
          faults++;
        end else begin
          exp_word = inst_exp.pop_front();
          if (inst_ret_data !== exp_word) begin
            $display("Mismatch %0s data: expected %h, actual %h", tag[0], exp_word, inst_ret_data);
            mismatches++;
          end
          if (inst_ret_last !== (inst_exp.size() == 0)) begin
            $display("Mismatch %0s last: expected %b, actual %b", tag[0],
                     inst_exp.size() == 0, inst_ret_last);
            mismatches++;
          end
        end
      end
      if (data_ret_valid) begin
        if (data_exp.size() == 0) begin
          $display("Data port returned a beat that was never requested");
          faults++;
        end else begin
          exp_word = data_exp.pop_front();
          if (data_ret_data !== exp_word) begin
            $display("Mismatch %0s data: expected %h, actual %h", tag[1], exp_word, data_ret_data);
            mismatches++;
          end
          if (data_ret_last !== (data_exp.size() == 0)) begin
            $display("Mismatch %0s last: expected %b, actual %b", tag[1],
                     data_exp.size() == 0, data_ret_last);
            mismatches++;
          end
        end
      end
    end
  end

endmodule

//--- tests/bridge_sva.sv
`timescale 1ns/1ps

module bridge_sva (
  input logic                 aclk,
  input logic                 reset,
  input logic                 arvalid,
  input logic                 arready,
  input bridge_pkg::rd_req_t  ar_slot,
  input logic                 awvalid,
  input logic                 awready,
  input bridge_pkg::addr_t    awaddr,
  input logic                 wvalid,
  input logic                 wready,
  input bridge_pkg::word_t    wdata,
  input bridge_pkg::strb_t    wstrb,
  input logic                 bready,
  input logic                 aw_done,
  input logic                 w_done,
  input logic                 inst_hit,
  input logic                 data_hit,
  input logic                 rlast,
  input bridge_pkg::beat_cnt_t inst_beat,
  input bridge_pkg::beat_cnt_t data_beat,
  input logic                 inst_ret_valid,
  input logic                 data_ret_valid
);

  a_ar_hold: assert property (@(posedge aclk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(ar_slot))
    else $error("AR payload changed or valid dropped before arready");

  a_aw_hold: assert property (@(posedge aclk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else $error("AW payload changed or valid dropped before awready");

  a_w_hold: assert property (@(posedge aclk) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable({wdata, wstrb}))
    else $error("W payload changed or valid dropped before wready");

  a_bready_order: assert property (@(posedge aclk) disable iff (reset)
    bready |-> aw_done && w_done)
    else $error("bready raised before both AW and W handshakes");

  // Fourth beat of a read has to be the last one
  a_line_beats: assert property (@(posedge aclk) disable iff (reset)
    (inst_hit && inst_beat == 2'd3) || (data_hit && data_beat == 2'd3) |-> rlast)
    else $error("Read returned more than LINE_BEATS beats");

  a_reset_idle: assert property (@(posedge aclk)
    $fell(reset) |-> !(arvalid || awvalid || wvalid || bready || inst_ret_valid || data_ret_valid))
    else $error("Control outputs high after reset");

endmodule

bind mem_bridge_top bridge_sva sva_0 (
  .aclk          (aclk),
  .reset         (reset),
  .arvalid       (arvalid),
  .arready       (arready),
  .ar_slot       (ar_slot),
  .awvalid       (awvalid),
  .awready       (awready),
  .awaddr        (awaddr),
  .wvalid        (wvalid),
  .wready        (wready),
  .wdata         (wdata),
  .wstrb         (wstrb),
  .bready        (bready),
  .aw_done       (write_issue_engine_0.aw_done),
  .w_done        (write_issue_engine_0.w_done),
  .inst_hit      (read_return_router_0.inst_hit),
  .data_hit      (read_return_router_0.data_hit),
  .rlast         (rlast),
  .inst_beat     (read_return_router_0.inst_beat),
  .data_beat     (read_return_router_0.data_beat),
  .inst_ret_valid(inst_ret_valid),
  .data_ret_valid(data_ret_valid)
);

//--- tests/mem_bridge_tb.sv
`timescale 1ns/1ps

module mem_bridge_tb;

  typedef enum logic [1:0] {PORT_INST, PORT_DATA, PORT_WR} port_e;

  typedef struct packed {
    logic [95:0]           name;
    port_e                 port;
    bridge_pkg::req_type_e kind;
    bridge_pkg::addr_t     addr;
    bridge_pkg::strb_t     strb;
    bridge_pkg::word_t     data;
    logic                  together;  // Starts in the same cycle as the next row
  } row_t;

  logic aclk;
  logic reset;
  logic inst_rd_req, data_rd_req, data_wr_req;
  bridge_pkg::req_type_e inst_rd_type, data_rd_type;
  bridge_pkg::addr_t inst_rd_addr, data_rd_addr, data_wr_addr;
  bridge_pkg::strb_t data_wr_wstrb;
  bridge_pkg::word_t data_wr_data;
  logic inst_rd_rdy, data_rd_rdy, data_wr_rdy;
  logic inst_ret_valid, inst_ret_last, data_ret_valid, data_ret_last;
  bridge_pkg::word_t inst_ret_data, data_ret_data;
  bridge_pkg::axi_id_t arid, rid, awid;
  bridge_pkg::addr_t araddr, awaddr;
  bridge_pkg::axi_len_t arlen, awlen;
  logic [2:0] arsize, awsize;
  logic [1:0] arburst, awburst;
  logic arvalid, arready, rlast, rvalid, rready;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  bridge_pkg::word_t rdata, wdata;
  bridge_pkg::strb_t wstrb;
  logic [95:0] inst_name, data_name, wr_name;
  int mismatches, faults;

  row_t rows[$];
  logic table_ready;
  integer seed;
  bridge_pkg::word_t mem [256];
  logic [1:0] pend_v;
  logic [7:0] pend_idx [2];
  bridge_pkg::axi_len_t pend_len [2];
  logic [7:0] r_idx;
  bridge_pkg::axi_len_t r_left;
  logic aw_got, w_got;
  logic [7:0] aw_idx;
  bridge_pkg::word_t w_data;
  bridge_pkg::strb_t w_strb;

  mem_bridge_top UUT (.*);

  bridge_checker chk (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  function automatic void add_row(logic [95:0] name, port_e port, bridge_pkg::req_type_e kind,
                                  bridge_pkg::addr_t addr, bridge_pkg::strb_t strb,
                                  bridge_pkg::word_t data, logic together);
    rows.push_back('{name, port, kind, addr, strb, data, together});
  endfunction

  // One row, from raising the request to its last return or write response
  task automatic run_row(int idx, int delay);
    row_t r;
    r = rows[idx];
    repeat (delay) @(posedge aclk);
    @(posedge aclk);
    case (r.port)
      PORT_INST: begin
        inst_rd_req <= 1'b1;
        inst_rd_type <= r.kind;
        inst_rd_addr <= r.addr;
        inst_name <= r.name;
        do @(negedge aclk); while (!inst_rd_rdy);
        @(posedge aclk);
        inst_rd_req <= 1'b0;
        do @(negedge aclk); while (!(inst_ret_valid && inst_ret_last));
      end
      PORT_DATA: begin
        data_rd_req <= 1'b1;
        data_rd_type <= r.kind;
        data_rd_addr <= r.addr;
        data_name <= r.name;
        do @(negedge aclk); while (!data_rd_rdy);
        @(posedge aclk);
        data_rd_req <= 1'b0;
        do @(negedge aclk); while (!(data_ret_valid && data_ret_last));
      end
      default: begin
        data_wr_req <= 1'b1;
        data_wr_addr <= r.addr;
        data_wr_wstrb <= r.strb;
        data_wr_data <= r.data;
        wr_name <= r.name;
        do @(negedge aclk); while (!data_wr_rdy);
        @(posedge aclk);
        data_wr_req <= 1'b0;
        do @(negedge aclk); while (!data_wr_rdy);
      end
    endcase
  endtask

  initial begin
    int i;
    table_ready = 1'b0;
    reset = 1'b1;
    {inst_rd_req, data_rd_req, data_wr_req} = '0;
    inst_rd_type = bridge_pkg::REQ_WORD;
    data_rd_type = bridge_pkg::REQ_WORD;
    {inst_rd_addr, data_rd_addr, data_wr_addr, data_wr_data} = '0;
    data_wr_wstrb = '0;
    {arready, awready, wready, rvalid, rlast, bvalid} = '0;
    rid = '0;
    rdata = '0;
    inst_name = '0;
    data_name = '0;
    wr_name = '0;
    add_row("inst_line", PORT_INST, bridge_pkg::REQ_LINE, 32'h104, 4'h0, 32'h0, 1'b0);
    add_row("data_word", PORT_DATA, bridge_pkg::REQ_WORD, 32'h20a, 4'h0, 32'h0, 1'b0);
    add_row("wr_partial", PORT_WR, bridge_pkg::REQ_WORD, 32'h208, 4'b0101, 32'h11223344, 1'b1);
    add_row("read_back", PORT_DATA, bridge_pkg::REQ_WORD, 32'h208, 4'h0, 32'h0, 1'b0);
    add_row("both_data", PORT_DATA, bridge_pkg::REQ_LINE, 32'h300, 4'h0, 32'h0, 1'b1);
    add_row("both_inst", PORT_INST, bridge_pkg::REQ_LINE, 32'h048, 4'h0, 32'h0, 1'b0);
    add_row("wr_full", PORT_WR, bridge_pkg::REQ_WORD, 32'h0f0, 4'hf, 32'hdeadbeef, 1'b0);
    add_row("inst_word", PORT_INST, bridge_pkg::REQ_WORD, 32'h0f3, 4'h0, 32'h0, 1'b0);
    add_row("data_line", PORT_DATA, bridge_pkg::REQ_LINE, 32'h0f4, 4'h0, 32'h0, 1'b0);
    add_row("pair_inst", PORT_INST, bridge_pkg::REQ_WORD, 32'h3f8, 4'h0, 32'h0, 1'b1);
    add_row("pair_data", PORT_DATA, bridge_pkg::REQ_WORD, 32'h010, 4'h0, 32'h0, 1'b0);
    table_ready = 1'b1;
    repeat (2) @(posedge aclk);
    reset <= 1'b0;
    i = 0;
    while (i < rows.size()) begin
      if (rows[i].together && i + 1 < rows.size()) begin
        // A read paired with a store starts one cycle later
        fork
          run_row(i, 0);
          run_row(i + 1, (rows[i].port == PORT_WR) ? 1 : 0);
        join
        i += 2;
      end else begin
        run_row(i, 0);
        i++;
      end
    end
    repeat (5) @(posedge aclk);
    $display("Checks done: %0d mismatches, %0d other errors", mismatches, faults);
    if (mismatches == 0 && faults == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    repeat (rows.size() * 200) @(posedge aclk);
    $display("Run timed out before all table rows completed");
    $display("Regression failed");
    $finish;
  end

  initial begin
    seed = 88816;
    for (int i = 0; i < 256; i++) mem[i] = {~i[7:0], i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'hc3};
  end

  // AXI memory model, data reads are served ahead of instruction reads
  always @(posedge aclk) begin
    if (reset) begin
      {arready, awready, wready, rvalid, rlast, bvalid} <= '0;
      pend_v <= '0;
      aw_got <= 1'b0;
      w_got <= 1'b0;
    end else begin
      arready <= 1'($random(seed));
      awready <= 1'($random(seed));
      wready <= 1'($random(seed));
      if (arvalid && arready) begin
        pend_v[arid[0]] <= 1'b1;
        pend_idx[arid[0]] <= araddr[9:2];
        pend_len[arid[0]] <= arlen;
      end
      if (rvalid && rready) begin
        if (rlast) begin
          rvalid <= 1'b0;
        end else begin
          rdata <= mem[r_idx + 8'd1];
          r_idx <= r_idx + 8'd1;
          r_left <= r_left - 8'd1;
          rlast <= (r_left == 8'd1);
        end
      end else if (!rvalid && pend_v != 2'b00) begin
        rvalid <= 1'b1;
        rid <= pend_v[1] ? bridge_pkg::ID_DATA : bridge_pkg::ID_INST;
        r_idx <= pend_idx[pend_v[1]];
        rdata <= mem[pend_idx[pend_v[1]]];
        r_left <= pend_len[pend_v[1]];
        rlast <= (pend_len[pend_v[1]] == 8'd0);
        pend_v[pend_v[1]] <= 1'b0;
      end
      if (awvalid && awready) begin
        aw_got <= 1'b1;
        aw_idx <= awaddr[9:2];
      end
      if (wvalid && wready) begin
        w_got <= 1'b1;
        w_data <= wdata;
        w_strb <= wstrb;
      end
      if (aw_got && w_got && !bvalid) begin
        for (int b = 0; b < 4; b++)
          if (w_strb[b]) mem[aw_idx][8*b +: 8] <= w_data[8*b +: 8];
        bvalid <= 1'b1;
        aw_got <= 1'b0;
        w_got <= 1'b0;
      end
      if (bvalid && bready) bvalid <= 1'b0;
    end
  end

endmodule
